// ==== gradient_combiner.sv ====
`timescale 1ns/1ps
`include "nn_params.svh"

module gradient_combiner #(
  parameter int NODES = `NN_NODES
) (
  input  logic                                         clock,
  input  logic                                         reset,

  input  logic [NODES-1:0]                             back_valid,
  input  nn_pkg::error_t [NODES-1:0][`NN_INPUTS-1:0]   back_data,
  output logic                                         back_ready,

  output logic                                         grad_valid,
  output nn_pkg::error_t [`NN_INPUTS-1:0]              grad_data,
  input  logic                                         grad_ready
);

  logic all_valid;
  logic accept;
  nn_pkg::error_t [`NN_INPUTS-1:0] node_sum;

  // Every neuron must present its errors before any is taken
  assign all_valid  = &back_valid;
  assign accept     = all_valid & (!grad_valid | grad_ready);
  assign back_ready = accept;

  // Sum wraps at the error width
  always_comb begin
    node_sum = '0;
    for (int n = 0; n < NODES; n++) begin
      for (int i = 0; i < `NN_INPUTS; i++) begin
        node_sum[i] = node_sum[i] + back_data[n][i];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      grad_valid <= 1'b0;
    end else if (accept) begin
      grad_valid <= 1'b1;
    end else if (grad_ready) begin
      grad_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      grad_data <= node_sum;
    end
  end

endmodule

// ==== neuron.sv ====
`timescale 1ns/1ps
`include "nn_params.svh"

module neuron #(
  parameter int INPUTS = `NN_INPUTS
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              train,

  input  logic                              fwd_valid,
  input  nn_pkg::activation_t [INPUTS-1:0]  fwd_data,
  output logic                              fwd_ready,

  input  logic                              err_valid,
  input  nn_pkg::error_t                    err_data,
  output logic                              err_ready,

  output logic                              act_valid,
  output nn_pkg::activation_t               act_data,
  input  logic                              act_ready,

  output logic                              back_valid,
  output nn_pkg::error_t [INPUTS-1:0]       back_data,
  input  logic                              back_ready
);

  localparam int FRAC = `NN_FRAC;
  localparam int RATE = `NN_RATE_SHIFT;
  localparam int CNT_W = (INPUTS > 1) ? $clog2(INPUTS) : 1;
  localparam logic [CNT_W-1:0] LAST = CNT_W'(INPUTS - 1);
  localparam int EXT_W = $bits(nn_pkg::extended_t);
  localparam int OPD_W = $bits(nn_pkg::operand_t);
  localparam int ERR_W = $bits(nn_pkg::error_t);

  typedef enum logic [2:0] {
    ST_READY,
    ST_MULTIPLY,
    ST_ACCUMULATE,
    ST_FINAL,
    ST_FORWARD,
    ST_DELTA,
    ST_BACKWARD,
    ST_UPDATE
  } state_t;

  state_t state;
  logic [CNT_W-1:0] counter;

  nn_pkg::operand_t  operand [INPUTS];
  nn_pkg::extended_t weight [INPUTS];
  nn_pkg::extended_t bias;
  nn_pkg::extended_t summand;
  nn_pkg::extended_t accumulator;
  nn_pkg::extended_t delta;

  // Full-width products, truncated only after the shift
  logic signed [EXT_W+OPD_W-1:0] mac_product;
  logic signed [ERR_W+OPD_W-1:0] delta_product;
  logic signed [2*EXT_W-1:0]     grad_product [INPUTS];
  logic signed [EXT_W+OPD_W-1:0] step_product [INPUTS];

  nn_pkg::operand_t table_activation;
  nn_pkg::operand_t table_derivative;

  logic fwd_fire;
  logic act_fire;
  logic err_fire;
  logic back_fire;

  sigmoid_table u_table (
    .index      (accumulator[2*FRAC-1:0]),
    .activation (table_activation),
    .derivative (table_derivative)
  );

  assign fwd_ready = (state == ST_READY);
  assign err_ready = (state == ST_DELTA);
  assign fwd_fire  = fwd_valid & fwd_ready;
  assign act_fire  = act_valid & act_ready;
  assign err_fire  = err_valid & err_ready;
  assign back_fire = back_valid & back_ready;

  // One shared multiplier walks the inputs during the forward pass
  assign mac_product   = weight[counter] * operand[counter];
  assign delta_product = err_data * table_derivative;

  for (genvar i = 0; i < INPUTS; i++) begin : g_input
    assign grad_product[i] = weight[i] * delta;
    assign step_product[i] = delta * operand[i];
  end

  always_ff @(posedge clock) begin
    if (fwd_fire) begin
      for (int i = 0; i < INPUTS; i++) begin
        operand[i] <= $signed({1'b0, fwd_data[i]});
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      counter <= '0;
    end else if (state == ST_MULTIPLY || state == ST_ACCUMULATE) begin
      counter <= (counter == LAST) ? '0 : counter + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (state == ST_MULTIPLY || state == ST_ACCUMULATE) begin
      summand <= nn_pkg::extended_t'(mac_product >>> FRAC);
    end
  end

  // Accumulator starts from the bias while idle
  always_ff @(posedge clock) begin
    if (state == ST_READY) begin
      accumulator <= bias;
    end else if (state == ST_ACCUMULATE || state == ST_FINAL) begin
      accumulator <= accumulator + summand;
    end
  end

  // Forward output register, loaded once then held until taken
  always_ff @(posedge clock) begin
    if (reset) begin
      act_valid <= 1'b0;
    end else if (state == ST_FORWARD && !act_valid) begin
      act_valid <= 1'b1;
    end else if (act_fire) begin
      act_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (state == ST_FORWARD && !act_valid) begin
      act_data <= table_activation[FRAC-1:0];
    end
  end

  always_ff @(posedge clock) begin
    if (err_fire) begin
      delta <= nn_pkg::extended_t'(delta_product >>> FRAC);
    end
  end

  // Gradients use the weights from before this update
  always_ff @(posedge clock) begin
    if (reset) begin
      bias <= '0;
      for (int i = 0; i < INPUTS; i++) begin
        weight[i] <= '0;
      end
    end else if (state == ST_BACKWARD) begin
      bias <= bias + (delta >>> RATE);
      for (int i = 0; i < INPUTS; i++) begin
        weight[i] <= weight[i] + nn_pkg::extended_t'(step_product[i] >>> (RATE + FRAC));
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == ST_BACKWARD) begin
      for (int i = 0; i < INPUTS; i++) begin
        back_data[i] <= nn_pkg::error_t'(grad_product[i] >>> FRAC);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      back_valid <= 1'b0;
    end else if (state == ST_UPDATE && !back_valid) begin
      back_valid <= 1'b1;
    end else if (back_fire) begin
      back_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_READY;
    end else begin
      case (state)
        ST_READY: begin
          if (fwd_fire) begin
            state <= ST_MULTIPLY;
          end
        end
        ST_MULTIPLY:   state <= (counter == LAST) ? ST_FINAL : ST_ACCUMULATE;
        ST_ACCUMULATE: begin
          if (counter == LAST) begin
            state <= ST_FINAL;
          end
        end
        ST_FINAL:      state <= ST_FORWARD;
        // Training mode is taken at the output transfer
        ST_FORWARD: begin
          if (act_fire) begin
            state <= train ? ST_DELTA : ST_READY;
          end
        end
        ST_DELTA: begin
          if (err_fire) begin
            state <= ST_BACKWARD;
          end
        end
        ST_BACKWARD:   state <= ST_UPDATE;
        ST_UPDATE: begin
          if (back_fire) begin
            state <= ST_READY;
          end
        end
        default:       state <= ST_READY;
      endcase
    end
  end

endmodule

// ==== nn_layer.sv ====
`timescale 1ns/1ps
`include "nn_params.svh"

module nn_layer (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic                                   train,

  input  logic                                   in_valid,
  input  nn_pkg::activation_t [`NN_INPUTS-1:0]   in_data,
  output logic                                   in_ready,

  output logic                                   out_valid,
  output nn_pkg::activation_t [`NN_NODES-1:0]    out_data,
  input  logic                                   out_ready,

  input  logic                                   err_valid,
  input  nn_pkg::error_t [`NN_NODES-1:0]         err_data,
  output logic                                   err_ready,

  output logic                                   grad_valid,
  output nn_pkg::error_t [`NN_INPUTS-1:0]        grad_data,
  input  logic                                   grad_ready
);

  logic [`NN_NODES-1:0] fwd_ready;
  logic [`NN_NODES-1:0] act_valid;
  logic [`NN_NODES-1:0] node_err_ready;
  logic [`NN_NODES-1:0] back_valid;
  nn_pkg::error_t [`NN_NODES-1:0][`NN_INPUTS-1:0] back_data;

  logic fwd_valid;
  logic act_ready;
  logic node_err_valid;
  logic back_ready;

  // Neurons run in lockstep, so a channel moves only when all agree
  assign in_ready       = &fwd_ready;
  assign fwd_valid      = in_valid & in_ready;
  assign out_valid      = &act_valid;
  assign act_ready      = out_ready & out_valid;
  assign err_ready      = &node_err_ready;
  assign node_err_valid = err_valid & err_ready;

  for (genvar n = 0; n < `NN_NODES; n++) begin : g_node
    neuron #(
      .INPUTS (`NN_INPUTS)
    ) u_neuron (
      .clock      (clock),
      .reset      (reset),
      .train      (train),
      .fwd_valid  (fwd_valid),
      .fwd_data   (in_data),
      .fwd_ready  (fwd_ready[n]),
      .err_valid  (node_err_valid),
      .err_data   (err_data[n]),
      .err_ready  (node_err_ready[n]),
      .act_valid  (act_valid[n]),
      .act_data   (out_data[n]),
      .act_ready  (act_ready),
      .back_valid (back_valid[n]),
      .back_data  (back_data[n]),
      .back_ready (back_ready)
    );
  end

  gradient_combiner #(
    .NODES (`NN_NODES)
  ) u_gradient_combiner (
    .clock      (clock),
    .reset      (reset),
    .back_valid (back_valid),
    .back_data  (back_data),
    .back_ready (back_ready),
    .grad_valid (grad_valid),
    .grad_data  (grad_data),
    .grad_ready (grad_ready)
  );

endmodule

// ==== nn_layer_tb.sv ====
`timescale 1ns/1ps
`include "nn_params.svh"

module nn_layer_tb;

  localparam int INPUTS = `NN_INPUTS;
  localparam int NODES = `NN_NODES;
  localparam int TIMEOUT = 200;

  typedef nn_pkg::activation_t [INPUTS-1:0] in_vec_t;
  typedef nn_pkg::activation_t [NODES-1:0]  out_vec_t;
  typedef nn_pkg::error_t [NODES-1:0]       err_vec_t;
  typedef nn_pkg::error_t [INPUTS-1:0]      grad_vec_t;

  logic      clock;
  logic      reset;
  logic      train;
  logic      in_valid;
  in_vec_t   in_data;
  logic      in_ready;
  logic      out_valid;
  out_vec_t  out_data;
  logic      out_ready;
  logic      err_valid;
  err_vec_t  err_data;
  logic      err_ready;
  logic      grad_valid;
  grad_vec_t grad_data;
  logic      grad_ready;

  // Shadow copy of the layer parameters
  nn_pkg::extended_t weight [NODES][INPUTS];
  nn_pkg::extended_t bias [NODES];
  nn_pkg::extended_t last_acc [NODES];
  in_vec_t           last_in;

  out_vec_t  exp_out [$];
  grad_vec_t exp_grad [$];
  string     test_name;
  logic [31:0] data_seed;
  logic [31:0] stall_seed;
  logic      stall_mode;
  logic      watch_err_ready;

  // Held outputs under back-pressure
  logic      out_held;
  logic      grad_held;
  out_vec_t  held_out;
  grad_vec_t held_grad;

  tb_clock_gen u_tb_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  nn_layer u_nn_layer (
    .clock      (clock),
    .reset      (reset),
    .train      (train),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_ready  (out_ready),
    .err_valid  (err_valid),
    .err_data   (err_data),
    .err_ready  (err_ready),
    .grad_valid (grad_valid),
    .grad_data  (grad_data),
    .grad_ready (grad_ready)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] value);
    return value * 32'd1664525 + 32'd1013904223;
  endfunction

  // Logistic of the low 16 accumulator bits taken as a signed value
  function automatic real logistic(input nn_pkg::extended_t acc);
    int a;
    a = $signed(acc[15:0]);
    return 1.0 / (1.0 + $exp(-6.0 * $itor(a) / 256.0));
  endfunction

  // Expected forward vector, keeps the accumulators for the delta
  function automatic out_vec_t forward_model(input in_vec_t x);
    out_vec_t result;
    nn_pkg::extended_t acc;
    for (int n = 0; n < NODES; n++) begin
      acc = bias[n];
      for (int i = 0; i < INPUTS; i++) begin
        acc = acc + nn_pkg::extended_t'((longint'(weight[n][i]) * longint'(x[i])) >>> 8);
      end
      last_acc[n] = acc;
      result[n] = nn_pkg::activation_t'($rtoi(256.0 * logistic(acc)));
    end
    last_in = x;
    return result;
  endfunction

  // Expected gradient vector, then the weight and bias step
  function automatic grad_vec_t backward_model(input err_vec_t err);
    grad_vec_t result;
    longint delta;
    int deriv;
    real s;
    result = '0;
    for (int n = 0; n < NODES; n++) begin
      s = logistic(last_acc[n]);
      deriv = $rtoi(256.0 * s * (1.0 - s));
      delta = (longint'(err[n]) * deriv) >>> 8;
      for (int i = 0; i < INPUTS; i++) begin
        result[i] = result[i] + nn_pkg::error_t'((longint'(weight[n][i]) * delta) >>> 8);
        weight[n][i] = weight[n][i] + nn_pkg::extended_t'(
          (delta * longint'(last_in[i])) >>> (`NN_RATE_SHIFT + 8));
      end
      bias[n] = bias[n] + nn_pkg::extended_t'(delta >>> `NN_RATE_SHIFT);
    end
    return result;
  endfunction

  function automatic in_vec_t random_input();
    in_vec_t x;
    for (int i = 0; i < INPUTS; i++) begin
      data_seed = lcg_step(data_seed);
      x[i] = data_seed[23:16];
    end
    return x;
  endfunction

  // Errors kept small so the logistic stays off its flat ends
  function automatic err_vec_t random_errors();
    err_vec_t e;
    for (int n = 0; n < NODES; n++) begin
      data_seed = lcg_step(data_seed);
      e[n] = nn_pkg::error_t'($signed(data_seed[25:16]));
    end
    return e;
  endfunction

  task automatic report_failure(input string text);
    $display("%s", text);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_activations(input string name, input out_vec_t expected,
                                   input out_vec_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_gradients(input string name, input grad_vec_t expected,
                                 input grad_vec_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_control(input string name, input int expected, input int actual);
    if (actual !== expected) begin
      report_failure($sformatf("Fail %s: expected %0d, actual %0d", name, expected, actual));
    end
  endtask

  task automatic wait_cycle();
    @(posedge clock);
    #1;
  endtask

  // Presents one input vector and returns once the layer has taken it
  task automatic send_input(input in_vec_t x, input out_vec_t expected);
    int cycles;
    exp_out.push_back(expected);
    in_data = x;
    in_valid = 1'b1;
    cycles = 0;
    do begin
      @(posedge clock);
      cycles++;
      if (cycles > TIMEOUT) begin
        report_failure("Timeout waiting for in_ready");
      end
    end while (!in_ready);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic send_errors(input err_vec_t err);
    int cycles;
    exp_grad.push_back(backward_model(err));
    err_data = err;
    err_valid = 1'b1;
    cycles = 0;
    do begin
      @(posedge clock);
      cycles++;
      if (cycles > TIMEOUT) begin
        report_failure("Timeout waiting for err_ready");
      end
    end while (!err_ready);
    #1;
    err_valid = 1'b0;
  endtask

  task automatic drain();
    int cycles;
    cycles = 0;
    while (exp_out.size() != 0 || exp_grad.size() != 0) begin
      wait_cycle();
      cycles++;
      if (cycles > TIMEOUT) begin
        report_failure("Timeout waiting for expected outputs to arrive");
      end
    end
  endtask

  task automatic run_passes(input int count, input logic training);
    in_vec_t x;
    for (int k = 0; k < count; k++) begin
      x = random_input();
      send_input(x, forward_model(x));
      if (training) begin
        send_errors(random_errors());
      end
    end
    drain();
  endtask

  // Ready inputs toggle in random stretches while back-pressure is on
  initial begin
    int stretch;
    stall_seed = 32'd17898;
    out_ready = 1'b1;
    grad_ready = 1'b1;
    stretch = 0;
    forever begin
      wait_cycle();
      if (!stall_mode) begin
        out_ready = 1'b1;
        grad_ready = 1'b1;
      end else if (stretch == 0) begin
        stall_seed = lcg_step(stall_seed);
        stretch = int'(stall_seed[18:16]) + 1;
        out_ready = stall_seed[24];
        grad_ready = stall_seed[25];
      end else begin
        stretch--;
      end
    end
  end

  // Compares every transfer and watches held outputs
  always @(posedge clock) begin
    if (reset) begin
      out_held = 1'b0;
      grad_held = 1'b0;
    end else begin
      if (out_held) begin
        check_control({test_name, "_out_hold"}, 1, out_valid);
        check_activations({test_name, "_out_hold"}, held_out, out_data);
      end
      if (grad_held) begin
        check_control({test_name, "_grad_hold"}, 1, grad_valid);
        check_gradients({test_name, "_grad_hold"}, held_grad, grad_data);
      end
      out_held = out_valid && !out_ready;
      grad_held = grad_valid && !grad_ready;
      held_out = out_data;
      held_grad = grad_data;
      if (watch_err_ready && err_ready) begin
        report_failure("err_ready went high while train was low");
      end
      if (out_valid && out_ready) begin
        if (exp_out.size() == 0) begin
          report_failure("Forward output transferred when none was expected");
        end
        check_activations(test_name, exp_out.pop_front(), out_data);
      end
      if (grad_valid && grad_ready) begin
        if (exp_grad.size() == 0) begin
          report_failure("Gradient transferred when none was expected");
        end
        check_gradients(test_name, exp_grad.pop_front(), grad_data);
      end
    end
  end

  initial begin
    int cycles;
    train = 1'b0;
    in_valid = 1'b0;
    in_data = '0;
    err_valid = 1'b0;
    err_data = '0;
    stall_mode = 1'b0;
    watch_err_ready = 1'b0;
    data_seed = 32'd17898;
    test_name = "reset_state";
    for (int n = 0; n < NODES; n++) begin
      bias[n] = '0;
      for (int i = 0; i < INPUTS; i++) begin
        weight[n][i] = '0;
      end
    end

    wait_cycle();
    cycles = 0;
    while (reset) begin
      wait_cycle();
      cycles++;
      if (cycles > TIMEOUT) begin
        report_failure("Timeout waiting for reset to be released");
      end
    end
    check_control("reset_out_valid", 0, out_valid);
    check_control("reset_grad_valid", 0, grad_valid);
    check_control("reset_in_ready", 1, in_ready);
    check_control("reset_err_ready", 0, err_ready);

    // Zero weights put every accumulator at the middle of the curve
    test_name = "untrained_forward";
    for (int k = 0; k < 3; k++) begin
      send_input(random_input(), {NODES{8'd128}});
      cycles = 0;
      while (!out_valid) begin
        wait_cycle();
        cycles++;
        if (cycles > TIMEOUT) begin
          report_failure("Timeout waiting for out_valid");
        end
      end
      check_control("untrained_latency", INPUTS + 2, cycles);
    end
    drain();

    test_name = "inference";
    watch_err_ready = 1'b1;
    run_passes(20, 1'b0);
    watch_err_ready = 1'b0;

    test_name = "training";
    train = 1'b1;
    run_passes(20, 1'b1);

    test_name = "backpressure_training";
    stall_mode = 1'b1;
    run_passes(15, 1'b1);
    train = 1'b0;
    test_name = "backpressure_inference";
    watch_err_ready = 1'b1;
    run_passes(15, 1'b0);
    watch_err_ready = 1'b0;
    stall_mode = 1'b0;
    drain();

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== nn_params.svh ====
`ifndef NN_PARAMS_SVH
`define NN_PARAMS_SVH

// Inputs per neuron
`define NN_INPUTS 2

// Neurons in the layer
`define NN_NODES 3

// Fraction bits of the fixed-point format
`define NN_FRAC 8

// Learning rate as a right shift of the update step
`define NN_RATE_SHIFT 2

`endif

// ==== nn_pkg.sv ====
`include "nn_params.svh"

package nn_pkg;

  // Unsigned forward value, all fraction bits
  typedef logic [`NN_FRAC-1:0] activation_t;

  // Activation widened by one sign bit
  typedef logic signed [`NN_FRAC:0] operand_t;

  // Wide signed value for weights, bias, accumulator and delta
  typedef logic signed [2*(`NN_FRAC+1)-1:0] extended_t;

  // Error passed between layers on the backward path
  typedef logic signed [2*`NN_FRAC-1:0] error_t;

endpackage

// ==== sigmoid_table.sv ====
`timescale 1ns/1ps
`include "nn_params.svh"

module sigmoid_table (
  input  logic [2*`NN_FRAC-1:0] index,
  output nn_pkg::operand_t      activation,
  output nn_pkg::operand_t      derivative
);

  localparam int FRAC = `NN_FRAC;
  localparam int DEPTH = 2 ** (2 * FRAC);
  localparam real STEEPNESS = 6.0;

  nn_pkg::operand_t activation_rom [DEPTH];
  nn_pkg::operand_t derivative_rom [DEPTH];

  // Logistic curve, input taken as a signed fixed-point value
  function automatic real logistic(input int value);
    return 1.0 / (1.0 + $exp(-STEEPNESS * $itor(value) / (2.0 ** FRAC)));
  endfunction

  // Index is the two's complement pattern of the accumulator
  initial begin
    real s;
    logic [2*FRAC-1:0] slot;
    for (int i = -DEPTH / 2; i < DEPTH / 2; i++) begin
      slot = i[2*FRAC-1:0];
      s = logistic(i);
      activation_rom[slot] = nn_pkg::operand_t'($rtoi((2.0 ** FRAC) * s));
      derivative_rom[slot] = nn_pkg::operand_t'($rtoi((2.0 ** FRAC) * s * (1.0 - s)));
    end
  end

  assign activation = activation_rom[index];
  assign derivative = derivative_rom[index];

endmodule

// ==== sources.f ====
+incdir+.
nn_pkg.sv
sigmoid_table.sv
neuron.sv
gradient_combiner.sv
nn_layer.sv
tb_clock_gen.sv
nn_layer_tb.sv

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD = 40.0,
  parameter int  RESET_CYCLES = 2
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2.0) clock = ~clock;
  end

  // Reset drops on an edge so the first cycle out of reset is a full one
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
  end

endmodule
